/* verilog/kd_tree_pkg.sv */
package kd_tree_pkg;

	localparam int dim_size    = 8;
	localparam int dim         = 3;
	localparam int data_size   = dim * dim_size;
	localparam int axis_size   = 2;
	localparam int tree_levels = 3;
	localparam int node_count  = (1 << tree_levels) - 1;
	// node i reaches its parent over link i and link 0 is the top
	localparam int link_count  = 2 * node_count + 1;

	localparam int path_step        = 2;
	localparam int fill_full_bit    = 0;
	localparam int fill_dropped_bit = 1;

	// route codes for fill and read, equal to the read path step codes
	localparam logic [1:0] target_self  = 2'd0;
	localparam logic [1:0] target_left  = 2'd1;
	localparam logic [1:0] target_right = 2'd2;
	localparam logic [1:0] target_none  = 2'd3;

	typedef enum logic [4:0] {
		nop                      = 5'h00,
		center_fill              = 5'h01,
		configure_sort_axis      = 5'h02,
		receive_center           = 5'h03,
		receive_done             = 5'h04,
		center_fill_ack          = 5'h05,
		configure_sort_axis_done = 5'h07,
		sort_step                = 5'h09,
		read_center              = 5'h0b,
		center_value             = 5'h0c,
		center_valid             = 5'h0f,
		dne                      = 5'h10,
		expose_center            = 5'h12,
		sort_done                = 5'h15,
		rst_done                 = 5'h1e,
		rst                      = 5'h1f
	} node_cmd_t;

	typedef enum logic [2:0] {
		idle,
		forward,
		gather,
		scatter,
		reply
	} node_phase_t;

	// answer code that closes each request
	function automatic node_cmd_t reply_of(input node_cmd_t cmd);
		case (cmd)
			rst:                 reply_of = rst_done;
			center_fill:         reply_of = center_fill_ack;
			configure_sort_axis: reply_of = configure_sort_axis_done;
			read_center:         reply_of = center_value;
			sort_step:           reply_of = sort_done;
			expose_center:       reply_of = center_valid;
			receive_center:      reply_of = receive_done;
			default:             reply_of = nop;
		endcase
	endfunction

endpackage

/* verilog/center_order.sv */
`timescale 1ns/10ps

module center_order (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              load_center,
	input  logic                              load_axis,
	input  logic                              clear,
	input  logic                              self_fill,
	input  logic [kd_tree_pkg::data_size-1:0] fill_word,
	input  logic [kd_tree_pkg::data_size-1:0] left_center,
	input  logic [kd_tree_pkg::data_size-1:0] right_center,
	output logic [kd_tree_pkg::data_size-1:0] center,
	output logic [kd_tree_pkg::axis_size-1:0] axis,
	output logic [kd_tree_pkg::data_size-1:0] new_left,
	output logic [kd_tree_pkg::data_size-1:0] new_self,
	output logic [kd_tree_pkg::data_size-1:0] new_right,
	output logic                              swapped
);
	import kd_tree_pkg::*;

	logic [axis_size-1:0] sel;
	logic [dim_size-1:0]  key_left;
	logic [dim_size-1:0]  key_self;
	logic [dim_size-1:0]  key_right;
	logic                 sort_swap;

	// axis 3 has no coordinate and falls back to axis 0
	assign sel       = (axis < dim) ? axis : '0;
	assign key_left  = left_center[sel*dim_size +: dim_size];
	assign key_self  = center[sel*dim_size +: dim_size];
	assign key_right = right_center[sel*dim_size +: dim_size];

	// stable three-way order, ties keep left, self, right
	always_comb begin
		new_left  = left_center;
		new_self  = center;
		new_right = right_center;
		sort_swap = 1'b0;
		if (key_left <= key_self) begin
			if (key_right < key_self) begin
				sort_swap = 1'b1;
				new_right = center;
				if (key_left <= key_right) begin
					new_self = right_center;
				end else begin
					new_left = right_center;
					new_self = left_center;
				end
			end
		end else begin
			sort_swap = 1'b1;
			if (key_left <= key_right) begin
				new_left = center;
				new_self = left_center;
			end else if (key_self <= key_right) begin
				new_left  = center;
				new_self  = right_center;
				new_right = left_center;
			end else begin
				new_left  = right_center;
				new_right = left_center;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			axis    <= '0;
			swapped <= 1'b0;
		end else if (clear) begin
			axis    <= '0;
			swapped <= 1'b0;
		end else begin
			if (load_axis)
				axis <= fill_word[axis_size-1:0];
			if (load_center && !self_fill)
				swapped <= sort_swap;
		end
	end

	always_ff @(posedge clk) begin
		if (clear)
			center <= '0;
		else if (load_center)
			center <= self_fill ? fill_word : new_self;
	end

endmodule

/* verilog/link_driver.sv */
`timescale 1ns/10ps

module link_driver (
	input  logic                              clk,
	input  logic                              rst_n,
	input  kd_tree_pkg::node_phase_t          phase,
	input  kd_tree_pkg::node_cmd_t            active_cmd,
	input  logic                              req_left,
	input  logic                              req_right,
	input  logic                              left_full,
	input  logic                              right_full,
	input  logic                              self_full,
	input  logic [1:0]                        fill_target,
	input  logic [kd_tree_pkg::data_size-1:0] center,
	input  logic [kd_tree_pkg::axis_size-1:0] axis,
	input  logic [kd_tree_pkg::data_size-1:0] new_left,
	input  logic [kd_tree_pkg::data_size-1:0] new_right,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_top,
	input  logic [kd_tree_pkg::data_size-1:0] child_value,
	input  logic                              left_swap,
	input  logic                              right_swap,
	input  logic                              swapped,
	output kd_tree_pkg::node_cmd_t            command_to_top,
	output kd_tree_pkg::node_cmd_t            command_to_left,
	output kd_tree_pkg::node_cmd_t            command_to_right,
	output logic [kd_tree_pkg::data_size-1:0] data_to_top,
	output logic [kd_tree_pkg::data_size-1:0] data_to_left,
	output logic [kd_tree_pkg::data_size-1:0] data_to_right
);
	import kd_tree_pkg::*;

	node_cmd_t            req_cmd;
	node_cmd_t            top_cmd;
	logic [data_size-1:0] fwd_data;
	logic [data_size-1:0] top_data;

	// request and data sent down in the current phase
	always_comb begin
		req_cmd  = nop;
		fwd_data = '0;
		case (phase)
			forward: begin
				req_cmd = active_cmd;
				case (active_cmd)
					center_fill:         fwd_data = data_from_top;
					configure_sort_axis: fwd_data = data_size'(axis);
					read_center:         fwd_data = data_from_top >> path_step;
					default:             fwd_data = '0;
				endcase
			end
			gather:  req_cmd = expose_center;
			scatter: req_cmd = receive_center;
			default: req_cmd = nop;
		endcase
	end

	always_comb begin
		top_cmd  = nop;
		top_data = '0;
		if (phase == reply) begin
			top_cmd = reply_of(active_cmd);
			case (active_cmd)
				center_fill: begin
					top_data[fill_full_bit]    = left_full && right_full && self_full;
					top_data[fill_dropped_bit] = (fill_target == target_none);
				end
				read_center:   top_data = (fill_target == target_self) ? center : child_value;
				expose_center: top_data = center;
				sort_step:     top_data[0] = left_swap || right_swap || swapped;
				default:       top_data = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			command_to_top   <= nop;
			command_to_left  <= nop;
			command_to_right <= nop;
			data_to_top      <= '0;
			data_to_left     <= '0;
			data_to_right    <= '0;
		end else begin
			command_to_top   <= top_cmd;
			data_to_top      <= top_data;
			command_to_left  <= req_left ? req_cmd : nop;
			command_to_right <= req_right ? req_cmd : nop;
			if (!req_left)
				data_to_left <= '0;
			else
				data_to_left <= (phase == scatter) ? new_left : fwd_data;
			if (!req_right)
				data_to_right <= '0;
			else
				data_to_right <= (phase == scatter) ? new_right : fwd_data;
		end
	end

endmodule

/* verilog/node_sequencer.sv */
`timescale 1ns/10ps

module node_sequencer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  kd_tree_pkg::node_cmd_t            command_from_top,
	input  kd_tree_pkg::node_cmd_t            command_from_left,
	input  kd_tree_pkg::node_cmd_t            command_from_right,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_top,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_left,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_right,
	output kd_tree_pkg::node_phase_t          phase,
	output kd_tree_pkg::node_cmd_t            active_cmd,
	output logic [1:0]                        fill_target,
	output logic                              left_full,
	output logic                              right_full,
	output logic                              self_full,
	output logic                              load_center,
	output logic                              load_axis,
	output logic                              capture_children,
	output logic                              clear,
	output logic                              req_left,
	output logic                              req_right
);
	import kd_tree_pkg::*;

	logic                 left_dne;
	logic                 right_dne;
	logic                 left_full_q;
	logic                 right_full_q;
	logic                 wait_left;
	logic                 wait_right;
	logic                 accept;
	logic                 children_quiet;
	logic                 send_left;
	logic                 send_right;
	logic [1:0]           fill_pick;
	logic [1:0]           read_pick;
	logic [1:0]           pick;
	logic [path_step-1:0] step;
	node_cmd_t            expected;

	assign left_dne   = (command_from_left == dne);
	assign right_dne  = (command_from_right == dne);
	assign left_full  = left_dne || left_full_q;
	assign right_full = right_dne || right_full_q;
	assign step       = data_from_top[path_step-1:0];

	// post-order fill: left subtree, right subtree, then this node
	always_comb begin
		if (!left_full)
			fill_pick = target_left;
		else if (!right_full)
			fill_pick = target_right;
		else if (!self_full)
			fill_pick = target_self;
		else
			fill_pick = target_none;
	end

	// a step towards a missing child ends here
	always_comb begin
		if (step == target_left && !left_dne)
			read_pick = target_left;
		else if (step == target_right && !right_dne)
			read_pick = target_right;
		else
			read_pick = target_self;
	end

	always_comb begin
		accept     = 1'b0;
		pick       = target_self;
		send_left  = 1'b0;
		send_right = 1'b0;
		if (phase == idle) begin
			case (command_from_top)
				rst, configure_sort_axis, sort_step: begin
					accept     = 1'b1;
					send_left  = !left_dne;
					send_right = !right_dne;
				end
				center_fill, read_center: begin
					accept     = 1'b1;
					pick       = (command_from_top == center_fill) ? fill_pick : read_pick;
					send_left  = (pick == target_left);
					send_right = (pick == target_right);
				end
				expose_center, receive_center: accept = 1'b1;
				default: accept = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (phase)
			gather:  expected = center_valid;
			scatter: expected = receive_done;
			default: expected = reply_of(active_cmd);
		endcase
	end

	// every request answered and every child back at nop
	assign children_quiet = !wait_left && !wait_right &&
		(command_from_left == nop || left_dne) && (command_from_right == nop || right_dne);

	assign clear            = accept && (command_from_top == rst);
	assign load_axis        = accept && (command_from_top == configure_sort_axis);
	assign load_center      = (accept && command_from_top == receive_center) ||
		(accept && command_from_top == center_fill && fill_pick == target_self) ||
		(phase == scatter && children_quiet);
	assign capture_children = (phase == forward) || (phase == gather);
	assign req_left         = wait_left;
	assign req_right        = wait_right;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase        <= idle;
			active_cmd   <= nop;
			fill_target  <= target_self;
			left_full_q  <= 1'b0;
			right_full_q <= 1'b0;
			self_full    <= 1'b0;
			wait_left    <= 1'b0;
			wait_right   <= 1'b0;
		end else begin
			case (phase)
				idle: if (accept) begin
					phase       <= forward;
					active_cmd  <= command_from_top;
					fill_target <= pick;
					wait_left   <= send_left;
					wait_right  <= send_right;
					if (command_from_top == rst) begin
						left_full_q  <= 1'b0;
						right_full_q <= 1'b0;
						self_full    <= 1'b0;
					end
					if (command_from_top == center_fill && fill_pick == target_self)
						self_full <= 1'b1;
				end
				forward, gather, scatter: begin
					if (wait_left && command_from_left == expected) begin
						wait_left <= 1'b0;
						if (active_cmd == center_fill)
							left_full_q <= data_from_left[fill_full_bit];
					end
					if (wait_right && command_from_right == expected) begin
						wait_right <= 1'b0;
						if (active_cmd == center_fill)
							right_full_q <= data_from_right[fill_full_bit];
					end
					if (children_quiet) begin
						if (phase == forward && active_cmd == sort_step && !left_dne) begin
							phase      <= gather;
							wait_left  <= 1'b1;
							wait_right <= !right_dne;
						end else if (phase == gather) begin
							phase      <= scatter;
							wait_left  <= 1'b1;
							wait_right <= !right_dne;
						end else begin
							phase <= reply;
						end
					end
				end
				reply: if (command_from_top == nop)
					phase <= idle;
				default: phase <= idle;
			endcase
		end
	end

endmodule

/* verilog/kd_node.sv */
`timescale 1ns/10ps

module kd_node (
	input  logic                              clk,
	input  logic                              rst_n,
	input  kd_tree_pkg::node_cmd_t            command_from_top,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_top,
	output kd_tree_pkg::node_cmd_t            command_to_top,
	output logic [kd_tree_pkg::data_size-1:0] data_to_top,
	input  kd_tree_pkg::node_cmd_t            command_from_left,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_left,
	output kd_tree_pkg::node_cmd_t            command_to_left,
	output logic [kd_tree_pkg::data_size-1:0] data_to_left,
	input  kd_tree_pkg::node_cmd_t            command_from_right,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_right,
	output kd_tree_pkg::node_cmd_t            command_to_right,
	output logic [kd_tree_pkg::data_size-1:0] data_to_right
);
	import kd_tree_pkg::*;

	node_phase_t          phase;
	node_cmd_t            active_cmd;
	logic [1:0]           fill_target;
	logic                 left_full;
	logic                 right_full;
	logic                 self_full;
	logic                 load_center;
	logic                 load_axis;
	logic                 capture_children;
	logic                 clear;
	logic                 req_left;
	logic                 req_right;
	logic                 self_fill;
	logic [data_size-1:0] center;
	logic [axis_size-1:0] axis;
	logic [data_size-1:0] new_left;
	logic [data_size-1:0] new_right;
	logic                 swapped;
	logic [data_size-1:0] left_center;
	logic [data_size-1:0] right_center;
	logic [data_size-1:0] child_value;
	logic                 left_swap;
	logic                 right_swap;

	// only the end of a sort step stores the ordered center
	assign self_fill   = (phase != scatter);
	assign child_value = (fill_target == target_right) ? right_center : left_center;

	always_ff @(posedge clk) begin
		if (capture_children &&
			(command_from_left == center_valid || command_from_left == center_value))
			left_center <= data_from_left;
		if (capture_children &&
			(command_from_right == center_valid || command_from_right == center_value))
			right_center <= data_from_right;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			left_swap  <= 1'b0;
			right_swap <= 1'b0;
		end else if (capture_children) begin
			if (command_from_left == sort_done)
				left_swap <= data_from_left[0];
			if (command_from_right == sort_done)
				right_swap <= data_from_right[0];
		end
	end

	node_sequencer node_sequencer_inst (.*);

	center_order center_order_inst (.*, .fill_word(data_from_top), .new_self());

	link_driver link_driver_inst (.*);

endmodule

/* verilog/kd_tree_top.sv */
`timescale 1ns/10ps

module kd_tree_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  kd_tree_pkg::node_cmd_t            command_from_top,
	input  logic [kd_tree_pkg::data_size-1:0] data_from_top,
	output kd_tree_pkg::node_cmd_t            command_to_top,
	output logic [kd_tree_pkg::data_size-1:0] data_to_top
);
	import kd_tree_pkg::*;

	// down runs from parent to child and up from child to parent
	node_cmd_t            cmd_down [link_count];
	logic [data_size-1:0] data_down [link_count];
	node_cmd_t            cmd_up [link_count];
	logic [data_size-1:0] data_up [link_count];

	assign cmd_down[0]    = command_from_top;
	assign data_down[0]   = data_from_top;
	assign command_to_top = cmd_up[0];
	assign data_to_top    = data_up[0];

	// heap order puts the children of node i on links 2i+1 and 2i+2
	for (genvar i = 0; i < node_count; i++) begin : g_node
		kd_node kd_node_inst (
			.clk               (clk),
			.rst_n             (rst_n),
			.command_from_top  (cmd_down[i]),
			.data_from_top     (data_down[i]),
			.command_to_top    (cmd_up[i]),
			.data_to_top       (data_up[i]),
			.command_from_left (cmd_up[2*i+1]),
			.data_from_left    (data_up[2*i+1]),
			.command_to_left   (cmd_down[2*i+1]),
			.data_to_left      (data_down[2*i+1]),
			.command_from_right(cmd_up[2*i+2]),
			.data_from_right   (data_up[2*i+2]),
			.command_to_right  (cmd_down[2*i+2]),
			.data_to_right     (data_down[2*i+2])
		);
	end

	// links below the leaves have no node behind them
	for (genvar j = node_count; j < link_count; j++) begin : g_stub
		assign cmd_up[j]  = dne;
		assign data_up[j] = '0;
	end

endmodule

/* dv/kd_tree_tb.sv */
`timescale 1ns/10ps

module kd_tree_tb;
	import kd_tree_pkg::*;

	localparam int reply_limit = 64 * tree_levels;
	localparam int sort_limit  = 24;
	// rst plus reads, fills, reads, three axis rounds, settling sorts with reads
	localparam int command_budget = (1 + node_count) + (node_count + 1) + node_count +
		3 * (2 + node_count) + (sort_limit + 1 + node_count);
	localparam int watchdog_cycles = command_budget * 64 * tree_levels + 16;

	logic                 clk;
	logic                 rst_n;
	node_cmd_t            command_from_top;
	logic [data_size-1:0] data_from_top;
	node_cmd_t            command_to_top;
	logic [data_size-1:0] data_to_top;

	integer               seed;
	logic [data_size-1:0] model_center [node_count];
	logic                 model_self_full [node_count];
	logic                 model_full [node_count];
	logic [axis_size-1:0] model_axis;

	kd_tree_top kd_tree_top_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.command_from_top(command_from_top),
		.data_from_top   (data_from_top),
		.command_to_top  (command_to_top),
		.data_to_top     (data_to_top)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
		$display("TEST FAILED");
		$fatal(1, "watchdog timeout");
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ordering key where axis 3 falls back to coordinate 0
	function automatic logic [dim_size-1:0] axis_key(input logic [data_size-1:0] c,
		input logic [axis_size-1:0] ax);
		int sel;
		sel = (ax == 2'd3) ? 0 : int'(ax);
		return c[sel*dim_size +: dim_size];
	endfunction

	// root step ends up in the lowest bits
	function automatic logic [data_size-1:0] path_of(input int node);
		int                   idx;
		logic [data_size-1:0] p;
		idx = node;
		p   = '0;
		while (idx != 0) begin
			p   = (p << path_step) | ((idx % 2 == 1) ? 1 : 2);
			idx = (idx - 1) / 2;
		end
		return p;
	endfunction

	task automatic issue_command(input node_cmd_t cmd, input logic [data_size-1:0] data,
		input node_cmd_t answer, output logic [data_size-1:0] reply);
		int waited;
		@(posedge clk);
		command_from_top <= cmd;
		data_from_top    <= data;
		waited = 0;
		@(negedge clk);
		while (command_to_top == nop) begin
			if (waited == reply_limit) begin
				$display("no reply to command %h within %0d cycles", cmd, reply_limit);
				$display("TEST FAILED");
				$fatal(1, "reply timeout");
			end
			waited++;
			@(negedge clk);
		end
		check_value("command_to_top", answer, command_to_top);
		reply = data_to_top;
		@(posedge clk);
		command_from_top <= nop;
		data_from_top    <= '0;
		waited = 0;
		@(negedge clk);
		// the reply must be withdrawn before the next request
		while (command_to_top != nop) begin
			if (waited == reply_limit) begin
				$display("reply to command %h was never withdrawn", cmd);
				$display("TEST FAILED");
				$fatal(1, "withdraw timeout");
			end
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic read_all;
		logic [data_size-1:0] reply;
		for (int i = 0; i < node_count; i++) begin
			issue_command(read_center, path_of(i), center_value, reply);
			check_value($sformatf("center of node %0d", i), model_center[i], reply);
		end
	endtask

	// walk down by the fill rule, then refresh the subtree full flags bottom-up
	task automatic fill_model(input logic [data_size-1:0] word,
		output logic [data_size-1:0] ack);
		int i;
		int l;
		int r;
		logic dropped;
		dropped = model_full[0];
		i = 0;
		while (!dropped) begin
			l = 2 * i + 1;
			r = 2 * i + 2;
			if (l < node_count && !model_full[l]) begin
				i = l;
			end else if (r < node_count && !model_full[r]) begin
				i = r;
			end else begin
				model_center[i]    = word;
				model_self_full[i] = 1'b1;
				break;
			end
		end
		for (int n = node_count - 1; n >= 0; n--) begin
			model_full[n] = model_self_full[n] &&
				(2 * n + 1 >= node_count || model_full[2 * n + 1]) &&
				(2 * n + 2 >= node_count || model_full[2 * n + 2]);
		end
		ack = '0;
		ack[fill_full_bit]    = model_full[0];
		ack[fill_dropped_bit] = dropped;
	endtask

	// deepest internal nodes first so every subtree is ordered before its parent
	task automatic sort_model(output logic swap);
		logic [data_size-1:0] vals [3];
		int                   ord [3];
		logic [data_size-1:0] tv;
		int                   ti;
		int                   k;
		swap = 1'b0;
		for (int i = node_count - 1; i >= 0; i--) begin
			if (2 * i + 2 < node_count) begin
				vals[0] = model_center[2 * i + 1];
				vals[1] = model_center[i];
				vals[2] = model_center[2 * i + 2];
				for (int j = 0; j < 3; j++)
					ord[j] = j;
				// insertion sort with a strict compare keeps ties in place
				for (int j = 1; j < 3; j++) begin
					k = j;
					while (k > 0 &&
						axis_key(vals[k-1], model_axis) > axis_key(vals[k], model_axis)) begin
						tv        = vals[k-1];
						vals[k-1] = vals[k];
						vals[k]   = tv;
						ti        = ord[k-1];
						ord[k-1]  = ord[k];
						ord[k]    = ti;
						k--;
					end
				end
				if (ord[0] != 0 || ord[1] != 1 || ord[2] != 2)
					swap = 1'b1;
				model_center[2 * i + 1] = vals[0];
				model_center[i]         = vals[1];
				model_center[2 * i + 2] = vals[2];
			end
		end
	endtask

	task automatic reset_tree;
		logic [data_size-1:0] reply;
		@(negedge clk);
		check_value("command_to_top", nop, command_to_top);
		check_value("data_to_top", '0, data_to_top);
		issue_command(rst, '0, rst_done, reply);
		check_value("data_to_top", '0, reply);
		for (int i = 0; i < node_count; i++) begin
			model_center[i]    = '0;
			model_self_full[i] = 1'b0;
			model_full[i]      = 1'b0;
		end
		model_axis = '0;
		read_all();
	endtask

	task automatic fill_tree;
		logic [data_size-1:0] word;
		logic [data_size-1:0] expected;
		logic [data_size-1:0] reply;
		for (int n = 0; n <= node_count; n++) begin
			word = $random(seed);
			fill_model(word, expected);
			issue_command(center_fill, word, center_fill_ack, reply);
			check_value($sformatf("fill ack %0d", n), expected, reply);
		end
	endtask

	task automatic sort_once(input int round);
		logic                 swap;
		logic [data_size-1:0] reply;
		sort_model(swap);
		issue_command(sort_step, '0, sort_done, reply);
		check_value($sformatf("sort_done data, step %0d", round), {{(data_size-1){1'b0}}, swap},
			reply);
	endtask

	task automatic sort_each_axis;
		logic [data_size-1:0] reply;
		for (int ax = 0; ax < dim; ax++) begin
			issue_command(configure_sort_axis, ax, configure_sort_axis_done, reply);
			check_value("axis reply data", '0, reply);
			model_axis = ax;
			sort_once(ax);
			read_all();
		end
	endtask

	task automatic sort_until_settled;
		logic                 moved;
		logic [data_size-1:0] snapshot [node_count];
		logic [data_size-1:0] reply;
		int                   rounds;
		rounds = 0;
		do begin
			if (rounds == sort_limit) begin
				$display("tree still reports swaps after %0d sort steps", sort_limit);
				$display("TEST FAILED");
				$fatal(1, "sort did not settle");
			end
			for (int i = 0; i < node_count; i++)
				snapshot[i] = model_center[i];
			sort_once(rounds);
			rounds++;
			moved = 1'b0;
			for (int i = 0; i < node_count; i++)
				if (snapshot[i] !== model_center[i])
					moved = 1'b1;
		end while (moved);
		// a settled tree reports no swap and keeps every center
		issue_command(sort_step, '0, sort_done, reply);
		check_value("sort_done data, settled tree", '0, reply);
		read_all();
	endtask

	initial begin
		seed             = 48677;
		rst_n            = 1'b0;
		command_from_top = nop;
		data_from_top    = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		reset_tree();
		fill_tree();
		read_all();
		sort_each_axis();
		sort_until_settled();
		$display("TEST OK");
		$finish;
	end

endmodule

/* kd_tree.f */
verilog/kd_tree_pkg.sv
verilog/center_order.sv
verilog/link_driver.sv
verilog/node_sequencer.sv
verilog/kd_node.sv
verilog/kd_tree_top.sv
dv/kd_tree_tb.sv
